// ==== list.f ====
design/uart_rx_pkg.sv
design/baud_tick_gen.sv
design/rx_shift_reg.sv
design/rx_bit_counter.sv
design/rx_frame_reg.sv
design/uart_rx_ctrl.sv
design/uart_rx.sv
verif/tb_clk_gen.sv
verif/uart_rx_asserts.sv
verif/tb_uart_rx.sv

// ==== Bender.yml ====
package:
  name: uart_rx

sources:
  # Receiver RTL, package first
  - files:
      - design/uart_rx_pkg.sv
      - design/baud_tick_gen.sv
      - design/rx_shift_reg.sv
      - design/rx_bit_counter.sv
      - design/rx_frame_reg.sv
      - design/uart_rx_ctrl.sv
      - design/uart_rx.sv

  # Testbench, top module tb_uart_rx
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/uart_rx_asserts.sv
      - verif/tb_uart_rx.sv

// ==== verif/tb_uart_rx.sv ====
// UART receiver testbench, TICK_DIV 4 so one bit is 16 clock cycles
// The stop-wait state is entered about five cycles into the following bit,
// so consecutive frames are separated by at least a quarter bit of idle line

`timescale 1ns/1ps

module tb_uart_rx
  import uart_rx_pkg::*;
;

  localparam int DATA_BITS   = DATA_BITS_DEF;
  localparam int TICK_DIV    = 4;
  localparam int BIT_CYC     = 4 * TICK_DIV;
  localparam int FRAME_CYC   = (DATA_BITS + 2) * BIT_CYC;
  localparam int DRIVE_DLY   = 1;
  localparam int RAND_FRAMES = 40;
  localparam int B2B_FRAMES  = 8;
  localparam int SEED        = 32'ha88f_6060;
  // Worst-case gaps for every frame, a few spare frames, then doubled
  localparam int TIMEOUT_CYC = 2 * (RAND_FRAMES * (FRAME_CYC + 2 * BIT_CYC)
                                  + B2B_FRAMES * (FRAME_CYC + TICK_DIV)
                                  + 4 * FRAME_CYC);

  logic      clk_i;
  logic      rst_i;
  logic      rx_line;
  rx_frame_t rx_frame_o;
  logic      rx_valid_o;
  logic      rx_idle_o;

  rx_frame_t exp_q[$];
  rx_frame_t exp_head;
  int        exp_count;
  int        err_cnt;
  int        err_at_start;
  int        test_num;
  int        tests_passed;
  int        tests_failed;
  int        frames_seen;
  int        cycle_cnt;

  tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(8)) i_tb_clk_gen (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  uart_rx #(.DATA_BITS(DATA_BITS), .TICK_DIV(TICK_DIV)) i_uart_rx (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rx_i       (rx_line),
    .rx_frame_o (rx_frame_o),
    .rx_valid_o (rx_valid_o),
    .rx_idle_o  (rx_idle_o)
  );

  // Every strobe must match the oldest frame sent
  frame_match_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (rx_valid_o && exp_count != 0) |-> (rx_frame_o == exp_head))
    else begin
      $display("MISMATCH rx_frame_o expected %h got %h",
               $sampled(exp_head), $sampled(rx_frame_o));
      err_cnt++;
    end

  unexpected_valid_a: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_valid_o |-> (exp_count != 0))
    else begin
      $error("rx_valid_o pulsed although no frame was expected");
      err_cnt++;
    end

  // Retire the head entry once its strobe has been checked
  always @(posedge clk_i) begin
    if (!rst_i && $sampled(rx_valid_o) && exp_q.size() != 0) begin
      exp_q.delete(0);
      frames_seen++;
      exp_count = exp_q.size();
      exp_head  = (exp_count != 0) ? exp_q[0] : '0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: run still busy after %0d cycles, expected frames never arrived",
               TIMEOUT_CYC);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic int error_total();
    return err_cnt + int'(i_uart_rx.i_uart_rx_ctrl.i_uart_rx_asserts.fail_cnt);
  endfunction

  task automatic expect_frame(input logic [DATA_BITS-1:0] data, input logic err);
    rx_frame_t f;
    f.data      = data;
    f.frame_err = err;
    exp_q.push_back(f);
    exp_count = exp_q.size();
    exp_head  = exp_q[0];
  endtask

  // Entered and left DRIVE_DLY after a rising edge
  task automatic hold_line(input logic level, input int cycles);
    rx_line = level;
    repeat (cycles) @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic send_frame(input logic [DATA_BITS-1:0] data, input logic stop_level);
    expect_frame(data, ~stop_level);
    hold_line(1'b0, BIT_CYC);
    for (int b = 0; b < DATA_BITS; b++) begin
      hold_line(data[b], BIT_CYC);
    end
    hold_line(stop_level, BIT_CYC);
  endtask

  task automatic check_idle();
    assert (rx_idle_o === 1'b1)
      else begin
        $error("receiver did not return to idle");
        err_cnt++;
      end
  endtask

  task automatic start_test();
    test_num++;
    err_at_start = error_total();
  endtask

  task automatic end_test(input string name);
    int errs;
    while (exp_count != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    #DRIVE_DLY;
    errs = error_total() - err_at_start;
    if (errs == 0) begin
      tests_passed++;
      $display("Test %0d %s: PASS (%0d frames so far)", test_num, name, frames_seen);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL with %0d errors", test_num, name, errs);
    end
  endtask

  task automatic test_reset_idle();
    start_test();
    hold_line(1'b1, 2 * BIT_CYC);
    check_idle();
    assert (rx_frame_o === '0)
      else begin
        $display("MISMATCH rx_frame_o expected %h got %h", {($bits(rx_frame_t)){1'b0}},
                 rx_frame_o);
        err_cnt++;
      end
    end_test("reset_idle");
  endtask

  task automatic test_random_frames();
    logic [DATA_BITS-1:0] data;
    start_test();
    for (int i = 0; i < RAND_FRAMES; i++) begin
      data = DATA_BITS'($urandom());
      send_frame(data, 1'b1);
      hold_line(1'b1, $urandom_range(2 * BIT_CYC, TICK_DIV));
    end
    end_test("random_frames");
  endtask

  task automatic test_short_gap();
    logic [DATA_BITS-1:0] data;
    start_test();
    for (int i = 0; i < B2B_FRAMES; i++) begin
      data = (i == 0) ? '0 : (i == 1) ? '1 : DATA_BITS'($urandom());
      send_frame(data, 1'b1);
      // Quarter bit of idle line, the shortest gap the FSM accepts
      hold_line(1'b1, TICK_DIV);
    end
    end_test("short_gap");
  endtask

  task automatic test_stop_error();
    start_test();
    send_frame(DATA_BITS'($urandom()), 1'b0);
    // Break condition, no new frame may start while the line is low
    hold_line(1'b0, 2 * BIT_CYC);
    hold_line(1'b1, BIT_CYC);
    check_idle();
    end_test("stop_error");
    check_idle();
  endtask

  task automatic test_start_glitch();
    start_test();
    // Start sample lands after the glitch, so start reads 1 and data all ones
    expect_frame('1, 1'b1);
    hold_line(1'b0, TICK_DIV);
    hold_line(1'b1, FRAME_CYC + 2 * BIT_CYC);
    end_test("start_glitch");
    check_idle();
  endtask

  initial begin
    rx_line      = 1'b1;
    exp_count    = 0;
    exp_head     = '0;
    err_cnt      = 0;
    err_at_start = 0;
    test_num     = 0;
    tests_passed = 0;
    tests_failed = 0;
    frames_seen  = 0;
    cycle_cnt    = 0;
    void'($urandom(SEED));

    wait (rst_i === 1'b1);
    wait (rst_i === 1'b0);
    @(posedge clk_i);
    #DRIVE_DLY;

    test_reset_idle();
    test_random_frames();
    test_short_gap();
    test_stop_error();
    test_start_glitch();

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d frames received",
             test_num, tests_passed, tests_failed, error_total(), frames_seen);
    if (tests_failed == 0 && error_total() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verif/uart_rx_asserts.sv ====
// Protocol checks on the receive controller outputs
// Bound into every uart_rx_ctrl instance; fail_cnt is read by the testbench

`timescale 1ns/1ps

module uart_rx_asserts
  import uart_rx_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  input rx_ctrl_t ctrl_i
);

  int unsigned fail_cnt = 0;

  // Sample, count and load are single-cycle strobes
  sipo_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl_i.en_sipo |=> !ctrl_i.en_sipo)
    else begin
      $error("en_sipo stayed high for more than one cycle");
      fail_cnt++;
    end

  cnt_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl_i.en_cnt |=> !ctrl_i.en_cnt)
    else begin
      $error("en_cnt stayed high for more than one cycle");
      fail_cnt++;
    end

  pipo_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl_i.en_pipo |=> !ctrl_i.en_pipo)
    else begin
      $error("en_pipo stayed high for more than one cycle");
      fail_cnt++;
    end

  // Idle means nothing else is running
  eor_alone_a: assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl_i.eor |-> !(ctrl_i.en_baud || ctrl_i.en_sipo || ctrl_i.en_cnt || ctrl_i.en_pipo))
    else begin
      $error("eor high together with an enable");
      fail_cnt++;
    end

  // Load is followed by the quiet stop-wait state
  pipo_quiet_a: assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl_i.en_pipo |=> (ctrl_i == '0))
    else begin
      $error("controls not all low in the cycle after en_pipo");
      fail_cnt++;
    end

endmodule

bind uart_rx_ctrl uart_rx_asserts i_uart_rx_asserts (
  .clk_i  (clk_i),
  .rst_i  (rst_i),
  .ctrl_i (ctrl_o)
);

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset source
// Reset is released a nanosecond after the last reset edge

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

// ==== design/uart_rx.sv ====
// UART receiver top: 1 start, DATA_BITS data LSB first, 1 stop, no parity
// One bit lasts 4*TICK_DIV clock cycles; rx_valid_o is a one-cycle strobe
// with no back-pressure, so the next frame overwrites an unread one

`timescale 1ns/1ps

module uart_rx
  import uart_rx_pkg::*;
#(
  parameter int DATA_BITS = DATA_BITS_DEF,
  parameter int TICK_DIV  = TICK_DIV_DEF
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      rx_i,
  output rx_frame_t rx_frame_o,
  output logic      rx_valid_o,
  output logic      rx_idle_o
);

  localparam int FRAME_BITS = DATA_BITS + 2;

  logic [1:0]            rx_meta;
  logic                  rx_sync;
  rx_ctrl_t              ctrl;
  logic                  baud_flag;
  logic                  cnt_flag;
  logic [FRAME_BITS-1:0] rx_word;

  // Two-flop synchronizer, idles at the line's mark level
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rx_meta <= 2'b11;
    end else begin
      rx_meta <= {rx_meta[0], rx_i};
    end
  end

  assign rx_sync = rx_meta[1];

  uart_rx_ctrl i_uart_rx_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rx_i        (rx_sync),
    .baud_flag_i (baud_flag),
    .cnt_flag_i  (cnt_flag),
    .ctrl_o      (ctrl)
  );

  baud_tick_gen #(.TICK_DIV(TICK_DIV)) i_baud_tick_gen (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .en_i   (ctrl.en_baud),
    .tick_o (baud_flag)
  );

  rx_shift_reg #(.FRAME_BITS(FRAME_BITS)) i_rx_shift_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .shift_i (ctrl.en_sipo),
    .rx_i    (rx_sync),
    .word_o  (rx_word)
  );

  rx_bit_counter #(.FRAME_BITS(FRAME_BITS)) i_rx_bit_counter (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clear_i (ctrl.eor),
    .inc_i   (ctrl.en_cnt),
    .last_o  (cnt_flag)
  );

  rx_frame_reg #(.DATA_BITS(DATA_BITS)) i_rx_frame_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .load_i  (ctrl.en_pipo),
    .word_i  (rx_word),
    .frame_o (rx_frame_o),
    .valid_o (rx_valid_o)
  );

  assign rx_idle_o = ctrl.eor;

endmodule

// ==== design/uart_rx_ctrl.sv ====
// Receive controller FSM, nine states s0..s8
// Two quarter ticks after the start edge it samples, then every four ticks
// en_baud stays high from s1 to s6 so the tick phase never slips between bits

`timescale 1ns/1ps

module uart_rx_ctrl
  import uart_rx_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     rx_i,
  input  logic     baud_flag_i,
  input  logic     cnt_flag_i,
  output rx_ctrl_t ctrl_o
);

  typedef enum logic [3:0] {
    s0 = 4'd0,
    s1 = 4'd1,
    s2 = 4'd2,
    s3 = 4'd3,
    s4 = 4'd4,
    s5 = 4'd5,
    s6 = 4'd6,
    s7 = 4'd7,
    s8 = 4'd8
  } state_t;

  // Output codes in field order {en_baud, en_sipo, en_cnt, en_pipo, eor}
  localparam rx_ctrl_t CTRL_WAIT   = 5'b10000;
  localparam rx_ctrl_t CTRL_IDLE   = 5'b00001;
  localparam rx_ctrl_t CTRL_SAMPLE = 5'b11000;
  localparam rx_ctrl_t CTRL_COUNT  = 5'b10100;
  localparam rx_ctrl_t CTRL_LOAD   = 5'b00110;
  localparam rx_ctrl_t CTRL_HOLD   = 5'b00000;

  state_t state_q;
  state_t state_d;

  always_comb begin
    ctrl_o  = CTRL_WAIT;
    state_d = state_q;
    case (state_q)
      s0: begin
        ctrl_o = CTRL_IDLE;
        if (!rx_i) begin
          state_d = s1;
        end
      end
      // Half a bit into the start bit
      s1: if (baud_flag_i) state_d = s2;
      s2: if (baud_flag_i) state_d = s3;
      s3: begin
        ctrl_o  = CTRL_SAMPLE;
        state_d = s4;
      end
      s4: if (baud_flag_i) state_d = s5;
      s5: begin
        if (baud_flag_i) begin
          state_d = cnt_flag_i ? s7 : s6;
        end
      end
      s6: begin
        ctrl_o  = CTRL_COUNT;
        state_d = s1;
      end
      s7: begin
        ctrl_o  = CTRL_LOAD;
        state_d = s8;
      end
      s8: begin
        // Hold until the line is back at the stop level
        ctrl_o = CTRL_HOLD;
        if (rx_i) begin
          state_d = s0;
        end
      end
      default: begin
        ctrl_o  = CTRL_IDLE;
        state_d = s0;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= s0;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== design/rx_frame_reg.sv ====
// Output register for one received frame
// DATA_BITS must equal DATA_BITS_DEF, the width of rx_frame_t.data
// A frame not read before the next load is overwritten

`timescale 1ns/1ps

module rx_frame_reg
  import uart_rx_pkg::*;
#(
  parameter int DATA_BITS = DATA_BITS_DEF
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 load_i,
  input  logic [DATA_BITS+1:0] word_i,
  output rx_frame_t            frame_o,
  output logic                 valid_o
);

  logic      start_bit;
  logic      stop_bit;
  rx_frame_t frame_q;
  logic      valid_q;

  // Frame layout in the sampled word
  assign start_bit = word_i[0];
  assign stop_bit  = word_i[DATA_BITS+1];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      frame_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= load_i;
      if (load_i) begin
        frame_q.data      <= word_i[DATA_BITS:1];
        // Start must read 0 and stop must read 1
        frame_q.frame_err <= start_bit | ~stop_bit;
      end
    end
  end

  assign frame_o = frame_q;
  assign valid_o = valid_q;

endmodule

// ==== design/rx_bit_counter.sv ====
// Counts the samples taken in the current frame
// last_o is high once the stop bit has been sampled (count == FRAME_BITS-1)

`timescale 1ns/1ps

module rx_bit_counter
  import uart_rx_pkg::*;
#(
  parameter int FRAME_BITS = FRAME_BITS_DEF
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic clear_i,
  input  logic inc_i,
  output logic last_o
);

  // One spare code, the controller also counts once during the load state
  localparam int CNT_W = $clog2(FRAME_BITS + 1);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (inc_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign last_o = (cnt_q == CNT_W'(FRAME_BITS - 1));

endmodule

// ==== design/rx_shift_reg.sv ====
// Serial-in parallel-out register for one UART frame
// Samples enter at the MSB end; after a full frame the start bit sits at bit 0
// and the stop bit at bit FRAME_BITS-1

`timescale 1ns/1ps

module rx_shift_reg
  import uart_rx_pkg::*;
#(
  parameter int FRAME_BITS = FRAME_BITS_DEF
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  shift_i,
  input  logic                  rx_i,
  output logic [FRAME_BITS-1:0] word_o
);

  logic [FRAME_BITS-1:0] word_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      word_q <= '0;
    end else if (shift_i) begin
      // Oldest sample drifts toward bit 0
      word_q <= {rx_i, word_q[FRAME_BITS-1:1]};
    end
  end

  assign word_o = word_q;

endmodule

// ==== design/baud_tick_gen.sv ====
// Quarter-bit tick generator
// First tick comes TICK_DIV cycles after en_i rises, then one every TICK_DIV
// Count is reloaded whenever en_i is low, so each frame starts in phase

`timescale 1ns/1ps

module baud_tick_gen
  import uart_rx_pkg::*;
#(
  parameter int TICK_DIV = TICK_DIV_DEF
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic en_i,
  output logic tick_o
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIV - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             tick_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q  <= RELOAD;
      tick_q <= 1'b0;
    end else if (!en_i) begin
      cnt_q  <= RELOAD;
      tick_q <= 1'b0;
    end else begin
      // Registered tick lands one cycle after the count hits zero
      tick_q <= (cnt_q == '0);
      cnt_q  <= (cnt_q == '0) ? RELOAD : cnt_q - 1'b1;
    end
  end

  assign tick_o = tick_q;

endmodule

// ==== design/uart_rx_pkg.sv ====
// Shared types and defaults for the UART receiver
// rx_frame_t.data is sized by DATA_BITS_DEF, so the top DATA_BITS must match it
// TICK_DIV_DEF is a short simulation value; set TICK_DIV from the real baud rate

package uart_rx_pkg;

  // Frame format: 1 start, DATA_BITS_DEF data (LSB first), 1 stop, no parity
  localparam int DATA_BITS_DEF  = 8;
  localparam int FRAME_BITS_DEF = DATA_BITS_DEF + 2;

  // Clock cycles per quarter bit period
  localparam int TICK_DIV_DEF = 4;

  // Controller enables, decoded per state
  typedef struct packed {
    logic en_baud;  // run quarter-bit tick generator
    logic en_sipo;  // take one line sample
    logic en_cnt;   // advance bit counter
    logic en_pipo;  // load output register
    logic eor;      // receiver idle
  } rx_ctrl_t;

  // Received frame as presented at the output
  typedef struct packed {
    logic [DATA_BITS_DEF-1:0] data;
    logic                     frame_err;
  } rx_frame_t;

endpackage
